// ==== build.f ====
rv_isa_pkg.sv
mem_bus_pkg.sv
lsu_decode.sv
lsu_lane_map.sv
tcm_sram.sv
lsu_load_extract.sv
lsu_top.sv
tb_clock_gen.sv
lsu_checker.sv
lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the lsu testbench
# any variable below can be set on the command line

VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with $(VERILATOR), run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== lsu_tb.sv ====
//////////////////////////////////////////////////
// lsu testbench, stimulus table, result queue,
// watchdog and summary
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

  // instruction kinds in the table
  localparam logic [1:0] k_ld = 2'd0;
  localparam logic [1:0] k_st = 2'd1;
  localparam logic [1:0] k_ot = 2'd2;
  // op-imm opcode, neither load nor store
  localparam logic [6:0] opc_alu = 7'b0010011;

  // short funct3 and status names for the table
  localparam logic [2:0] lb  = rv_isa_pkg::f3_lb;
  localparam logic [2:0] lh  = rv_isa_pkg::f3_lh;
  localparam logic [2:0] lw  = rv_isa_pkg::f3_lw;
  localparam logic [2:0] lbu = rv_isa_pkg::f3_lbu;
  localparam logic [2:0] lhu = rv_isa_pkg::f3_lhu;
  localparam logic [2:0] sb  = rv_isa_pkg::f3_sb;
  localparam logic [2:0] sh  = rv_isa_pkg::f3_sh;
  localparam logic [2:0] sw  = rv_isa_pkg::f3_sw;
  localparam mem_bus_pkg::sts_t ok  = mem_bus_pkg::sts_ok;
  localparam mem_bus_pkg::sts_t mal = mem_bus_pkg::sts_mal;
  localparam mem_bus_pkg::sts_t ill = mem_bus_pkg::sts_ill;

  // one table row
  typedef struct {
    logic [1:0]        kind;
    logic [2:0]        f3;
    logic [4:0]        rd;
    logic [31:0]       base;
    logic [11:0]       ofs;
    logic [31:0]       wdt;
    int                gap;
    mem_bus_pkg::sts_t sts;
    logic [31:0]       rdt;
  } entry_t;

  logic              clk;
  logic              rst;
  logic              in_vld;
  rv_isa_pkg::insn_u in_insn;
  logic [31:0]       in_base;
  logic [31:0]       in_wdt;
  logic              out_vld;
  mem_bus_pkg::sts_t out_sts;
  logic [4:0]        out_rd;
  logic [31:0]       out_rdt;

  entry_t tbl[$];
  // table indices of instructions in flight
  int     exp_q[$];
  int     errors = 0;
  int     passed = 0;
  int     failed = 0;
  bit     tbl_done = 1'b0;

  tb_clock_gen clk_i (
    .clk (clk),
    .rst (rst)
  );

  lsu_top #(.addr_w(8)) dut_i (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (in_vld),
    .in_insn (in_insn),
    .in_base (in_base),
    .in_wdt  (in_wdt),
    .out_vld (out_vld),
    .out_sts (out_sts),
    .out_rd  (out_rd),
    .out_rdt (out_rdt)
  );

  //////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////

  task automatic add_entry(input logic [1:0] kind, input logic [2:0] f3,
                           input logic [4:0] rd, input logic [31:0] base,
                           input logic [11:0] ofs, input logic [31:0] wdt, input int gap,
                           input mem_bus_pkg::sts_t sts, input logic [31:0] rdt);
    entry_t e;
    e.kind = kind;
    e.f3   = f3;
    e.rd   = rd;
    e.base = base;
    e.ofs  = ofs;
    e.wdt  = wdt;
    e.gap  = gap;
    e.sts  = sts;
    e.rdt  = rdt;
    tbl.push_back(e);
  endtask

  // kind, funct3, rd, base, imm, store data, gap, status, load data
  task automatic fill_table();
    // word store, load right behind it
    add_entry(k_st, sw,  5'd0,  32'h100, 12'h000, 32'h1234_5678, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd5,  32'h100, 12'h000, 32'h0,         0, ok,  32'h1234_5678);
    // bytes into all four lanes of 0x104
    add_entry(k_st, sw,  5'd0,  32'h104, 12'h000, 32'h0,         1, ok,  32'h0);
    add_entry(k_st, sb,  5'd0,  32'h104, 12'h000, 32'h1111_11aa, 0, ok,  32'h0);
    add_entry(k_st, sb,  5'd0,  32'h104, 12'h001, 32'h2222_22bb, 0, ok,  32'h0);
    add_entry(k_st, sb,  5'd0,  32'h104, 12'h002, 32'h3333_33cc, 0, ok,  32'h0);
    add_entry(k_st, sb,  5'd0,  32'h104, 12'h003, 32'h4444_44dd, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd6,  32'h104, 12'h000, 32'h0,         2, ok,  32'hddcc_bbaa);
    // halves into 0x108
    add_entry(k_st, sw,  5'd0,  32'h108, 12'h000, 32'hffff_ffff, 0, ok,  32'h0);
    add_entry(k_st, sh,  5'd0,  32'h108, 12'h000, 32'habcd_1234, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd7,  32'h108, 12'h000, 32'h0,         0, ok,  32'hffff_1234);
    add_entry(k_st, sh,  5'd0,  32'h108, 12'h002, 32'h0000_5678, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd8,  32'h108, 12'h000, 32'h0,         3, ok,  32'h5678_1234);
    // sign and zero extension, bytes 81 7f f0 80
    add_entry(k_st, sw,  5'd0,  32'h10c, 12'h000, 32'h80f0_7f81, 0, ok,  32'h0);
    add_entry(k_ld, lb,  5'd9,  32'h10c, 12'h000, 32'h0,         0, ok,  32'hffff_ff81);
    add_entry(k_ld, lbu, 5'd10, 32'h10c, 12'h000, 32'h0,         0, ok,  32'h0000_0081);
    add_entry(k_ld, lb,  5'd11, 32'h10c, 12'h001, 32'h0,         0, ok,  32'h0000_007f);
    add_entry(k_ld, lb,  5'd12, 32'h10c, 12'h003, 32'h0,         0, ok,  32'hffff_ff80);
    add_entry(k_ld, lbu, 5'd13, 32'h10c, 12'h002, 32'h0,         0, ok,  32'h0000_00f0);
    add_entry(k_ld, lh,  5'd14, 32'h10c, 12'h000, 32'h0,         0, ok,  32'h0000_7f81);
    add_entry(k_ld, lh,  5'd15, 32'h10c, 12'h002, 32'h0,         0, ok,  32'hffff_80f0);
    add_entry(k_ld, lhu, 5'd16, 32'h10c, 12'h002, 32'h0,         1, ok,  32'h0000_80f0);
    // misaligned, memory must stay as it was
    add_entry(k_ld, lh,  5'd17, 32'h100, 12'h001, 32'h0,         0, mal, 32'h0);
    add_entry(k_ld, lw,  5'd18, 32'h100, 12'h002, 32'h0,         0, mal, 32'h0);
    add_entry(k_st, sw,  5'd0,  32'h104, 12'h001, 32'hdead_beef, 0, mal, 32'h0);
    add_entry(k_st, sh,  5'd0,  32'h104, 12'h003, 32'h0000_9999, 0, mal, 32'h0);
    add_entry(k_ld, lw,  5'd19, 32'h104, 12'h000, 32'h0,         0, ok,  32'hddcc_bbaa);
    // not a load/store, then a reserved load funct3
    add_entry(k_ot, 3'b000, 5'd22, 32'h100, 12'h000, 32'h0,      0, ill, 32'h0);
    add_entry(k_ld, 3'b011, 5'd23, 32'h100, 12'h000, 32'h0,      1, ill, 32'h0);
    // negative imm lands on 0x110
    add_entry(k_st, sw,  5'd0,  32'h120, 12'hff0, 32'hcafe_f00d, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd24, 32'h100, 12'h010, 32'h0,         0, ok,  32'hcafe_f00d);
    // imm 0x02b uses both imm_hi and imm_lo, byte 0x12b
    add_entry(k_st, sw,  5'd0,  32'h128, 12'h000, 32'h0,         0, ok,  32'h0);
    add_entry(k_st, sb,  5'd0,  32'h100, 12'h02b, 32'h0000_005a, 0, ok,  32'h0);
    add_entry(k_ld, lw,  5'd25, 32'h128, 12'h000, 32'h0,         0, ok,  32'h5a00_0000);
    add_entry(k_ld, lbu, 5'd26, 32'h130, 12'hffb, 32'h0,         0, ok,  32'h0000_005a);
  endtask

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // encode one instruction word through the matching view
  function automatic rv_isa_pkg::insn_u make_insn(input logic [1:0] kind,
                                                  input logic [2:0] f3,
                                                  input logic [4:0] rd,
                                                  input logic [11:0] imm);
    rv_isa_pkg::insn_u insn;
    if (kind == k_st) begin
      insn.st.imm_hi = imm[11:5];
      insn.st.rs2    = 5'd2;
      insn.st.rs1    = 5'd1;
      insn.st.funct3 = f3;
      insn.st.imm_lo = imm[4:0];
      insn.st.opcode = rv_isa_pkg::opc_store;
    end else begin
      insn.ld.imm    = imm;
      insn.ld.rs1    = 5'd1;
      insn.ld.funct3 = f3;
      insn.ld.rd     = rd;
      insn.ld.opcode = (kind == k_ld) ? rv_isa_pkg::opc_load : opc_alu;
    end
    return insn;
  endfunction

  function automatic string kind_name(input logic [1:0] kind);
    if (kind == k_ld) begin
      return "load ";
    end else if (kind == k_st) begin
      return "store";
    end
    return "other";
  endfunction

  // compare one result against its table row
  task automatic check_result(input int idx);
    entry_t      e;
    int          bad;
    logic [31:0] adr;
    e   = tbl[idx];
    bad = 0;
    adr = e.base + {{20{e.ofs[11]}}, e.ofs};
    assert (out_sts == e.sts) else begin
      $display("CHECK FAILED time %0t out_sts got %0d expected %0d", $time, out_sts, e.sts);
      bad++;
    end
    // stores carry no rd
    if (e.kind != k_st) begin
      assert (out_rd == e.rd) else begin
        $display("CHECK FAILED time %0t out_rd got %0d expected %0d", $time, out_rd, e.rd);
        bad++;
      end
    end
    // data only counts for clean loads
    if (e.kind == k_ld && e.sts == ok) begin
      assert (out_rdt === e.rdt) else begin
        $display("CHECK FAILED time %0t out_rdt got %h expected %h", $time, out_rdt, e.rdt);
        bad++;
      end
    end
    errors += bad;
    if (bad == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test %0d %s adr %h: %s", idx, kind_name(e.kind), adr,
             (bad == 0) ? "pass" : "fail");
  endtask

  //////////////////////////////////////////////////
  // result monitor, samples on the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      assert (out_vld === 1'b0) else begin
        $display("out_vld is not low during reset at %0t", $time);
        errors++;
      end
    end else if (out_vld !== 1'b0) begin
      assert (out_vld === 1'b1 && exp_q.size() != 0) else begin
        $display("result or unknown out_vld at %0t with nothing in flight", $time);
        errors++;
      end
      if (out_vld === 1'b1 && exp_q.size() != 0) begin
        check_result(exp_q.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    in_vld  = 1'b0;
    in_insn = '0;
    in_base = '0;
    in_wdt  = '0;
    fill_table();
    tbl_done = 1'b1;
    @(posedge clk);
    while (rst) @(posedge clk);
    // a few idle cycles, out_vld has to stay low
    repeat (3) @(posedge clk);
    foreach (tbl[i]) begin
      @(posedge clk);
      in_vld  <= 1'b1;
      in_insn <= make_insn(tbl[i].kind, tbl[i].f3, tbl[i].rd, tbl[i].ofs);
      in_base <= tbl[i].base;
      in_wdt  <= tbl[i].wdt;
      exp_q.push_back(i);
      repeat (tbl[i].gap) begin
        @(posedge clk);
        in_vld <= 1'b0;
      end
    end
    @(posedge clk);
    in_vld <= 1'b0;
    // drain the pipeline, then leave room for stray pulses
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tbl.size(), passed, failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // limit scales with table length and the longest gap
  initial begin : watchdog
    int max_gap;
    int limit;
    max_gap = 0;
    wait (tbl_done);
    foreach (tbl[i]) begin
      if (tbl[i].gap > max_gap) begin
        max_gap = tbl[i].gap;
      end
    end
    limit = tbl.size() * (max_gap + 4) + 20;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, %0d results never arrived", limit, exp_q.size());
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsu_checker.sv ====
//////////////////////////////////////////////////
// lsu latency and sram request assertions
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_checker (
  input logic                          clk,
  input logic                          rst,
  input logic                          in_vld,
  input logic                          out_vld,
  input logic                          mem_en,
  input logic                          mem_we,
  input logic [mem_bus_pkg::ben_w-1:0] mem_ben,
  input mem_bus_pkg::sts_t             d_sts
);

  // result pulse exactly three edges after the strobe
  a_latency: assert property (
    @(posedge clk) disable iff (rst) out_vld == $past(in_vld, 3)
  ) else $error("out_vld does not follow in_vld by three cycles");

  // one sram request per clean strobe, one cycle later
  // failed instructions never reach the sram
  a_gate: assert property (
    @(posedge clk) disable iff (rst)
      mem_en == ($past(in_vld) && (d_sts == mem_bus_pkg::sts_ok))
  ) else $error("mem_en does not match a clean strobe one cycle earlier");

  // a write always touches at least one lane
  a_ben: assert property (
    @(posedge clk) disable iff (rst) mem_we |-> (mem_ben != '0)
  ) else $error("mem_we high with no byte enable");

  // valid is known once reset is done
  a_known: assert property (
    @(posedge clk) disable iff (rst) !$isunknown(out_vld)
  ) else $error("out_vld unknown after reset");

endmodule

// attach to the lsu top level
bind lsu_top lsu_checker checker_i (
  .clk     (clk),
  .rst     (rst),
  .in_vld  (in_vld),
  .out_vld (out_vld),
  .mem_en  (mem_en),
  .mem_we  (mem_we),
  .mem_ben (mem_ben),
  .d_sts   (d_sts)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
//////////////////////////////////////////////////
// testbench clock and synchronous reset source
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned period  = 20,
  parameter int unsigned rst_cyc = 3
) (
  output logic clk,
  output logic rst
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset covers the first rst_cyc rising edges
  initial begin
    rst = 1'b1;
    repeat (rst_cyc) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
//////////////////////////////////////////////////
// lsu top, decode, lane map, sram and extract
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
  parameter int unsigned addr_w = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_vld,
  input  rv_isa_pkg::insn_u            in_insn,
  input  logic [mem_bus_pkg::xlen-1:0] in_base,
  input  logic [mem_bus_pkg::xlen-1:0] in_wdt,
  output logic                         out_vld,
  output mem_bus_pkg::sts_t            out_sts,
  output logic [4:0]                   out_rd,
  output logic [mem_bus_pkg::xlen-1:0] out_rdt
);

  // decode stage outputs
  logic                          d_vld;
  logic                          d_we;
  logic                          d_sign;
  logic [mem_bus_pkg::xlen-1:0]  d_adr;
  logic [mem_bus_pkg::xlen-1:0]  d_wdt;
  mem_bus_pkg::siz_t             d_siz;
  logic [4:0]                    d_rd;
  mem_bus_pkg::sts_t             d_sts;
  // sram request and response
  logic                          mem_en;
  logic                          mem_we;
  logic [addr_w-1:0]             mem_adr;
  logic [mem_bus_pkg::ben_w-1:0] mem_ben;
  logic [mem_bus_pkg::xlen-1:0]  mem_wdt;
  logic [mem_bus_pkg::xlen-1:0]  mem_rdt;
  logic [1:0]                    x_ofs;

  //////////////////////////////////////////////////
  // pipeline
  //////////////////////////////////////////////////

  lsu_decode decode_i (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (in_vld),
    .in_insn (in_insn),
    .in_base (in_base),
    .in_wdt  (in_wdt),
    .d_vld   (d_vld),
    .d_we    (d_we),
    .d_sign  (d_sign),
    .d_adr   (d_adr),
    .d_wdt   (d_wdt),
    .d_siz   (d_siz),
    .d_rd    (d_rd),
    .d_sts   (d_sts)
  );

  // combinational, same cycle as decode output
  lsu_lane_map #(.addr_w(addr_w)) lane_i (
    .d_vld   (d_vld),
    .d_we    (d_we),
    .d_adr   (d_adr),
    .d_wdt   (d_wdt),
    .d_siz   (d_siz),
    .d_sts   (d_sts),
    .mem_en  (mem_en),
    .mem_we  (mem_we),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .x_ofs   (x_ofs)
  );

  tcm_sram #(.addr_w(addr_w)) sram_i (
    .clk     (clk),
    .mem_en  (mem_en),
    .mem_we  (mem_we),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  // sideband goes straight from decode, bypassing lane map
  lsu_load_extract extract_i (
    .clk     (clk),
    .rst     (rst),
    .d_vld   (d_vld),
    .d_sign  (d_sign),
    .d_siz   (d_siz),
    .d_rd    (d_rd),
    .d_sts   (d_sts),
    .x_ofs   (x_ofs),
    .mem_rdt (mem_rdt),
    .out_vld (out_vld),
    .out_sts (out_sts),
    .out_rd  (out_rd),
    .out_rdt (out_rdt)
  );

endmodule

`default_nettype wire

// ==== lsu_load_extract.sv ====
//////////////////////////////////////////////////
// lsu result stage, read rotation, sign extension
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_load_extract (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         d_vld,
  input  logic                         d_sign,
  input  mem_bus_pkg::siz_t            d_siz,
  input  logic [4:0]                   d_rd,
  input  mem_bus_pkg::sts_t            d_sts,
  input  logic [1:0]                   x_ofs,
  input  logic [mem_bus_pkg::xlen-1:0] mem_rdt,
  output logic                         out_vld,
  output mem_bus_pkg::sts_t            out_sts,
  output logic [4:0]                   out_rd,
  output logic [mem_bus_pkg::xlen-1:0] out_rdt
);

  // sideband, aligned with mem_rdt
  logic                               r_vld;
  logic                               r_sign;
  mem_bus_pkg::siz_t                  r_siz;
  logic [4:0]                         r_rd;
  mem_bus_pkg::sts_t                  r_sts;
  logic [1:0]                         r_ofs;
  // read data lanes
  logic [mem_bus_pkg::ben_w-1:0][7:0] rdt_lane;
  logic [mem_bus_pkg::ben_w-1:0][7:0] sh_lane;
  logic [mem_bus_pkg::xlen-1:0]       ext;

  //////////////////////////////////////////////////
  // first stage, wait for the sram read
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      r_vld <= 1'b0;
    end else begin
      r_vld <= d_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (d_vld) begin
      r_sign <= d_sign;
      r_siz  <= d_siz;
      r_rd   <= d_rd;
      r_sts  <= d_sts;
      r_ofs  <= x_ofs;
    end
  end

  //////////////////////////////////////////////////
  // rotate down to lane 0 and extend
  //////////////////////////////////////////////////

  assign rdt_lane = mem_rdt;

  // lane i takes byte (i + offset) mod lanes
  for (genvar i = 0; i < mem_bus_pkg::ben_w; i++) begin : g_lane
    logic [1:0] sel;
    assign sel        = 2'(i) + r_ofs;
    assign sh_lane[i] = rdt_lane[sel];
  end

  always_comb begin
    case (r_siz)
      mem_bus_pkg::siz_b: begin
        ext = {{(mem_bus_pkg::xlen-8){r_sign & sh_lane[0][7]}}, sh_lane[0]};
      end
      mem_bus_pkg::siz_h: begin
        ext = {{(mem_bus_pkg::xlen-16){r_sign & sh_lane[1][7]}}, sh_lane[1], sh_lane[0]};
      end
      default: ext = sh_lane;
    endcase
  end

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= r_vld;
    end
  end

  // rdt also captured for stores, consumer ignores it
  always_ff @(posedge clk) begin
    if (r_vld) begin
      out_sts <= r_sts;
      out_rd  <= r_rd;
      out_rdt <= ext;
    end
  end

endmodule

`default_nettype wire

// ==== tcm_sram.sv ====
//////////////////////////////////////////////////
// byte writable single port sram, registered read
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tcm_sram #(
  parameter int unsigned addr_w = 8
) (
  input  logic                          clk,
  input  logic                          mem_en,
  input  logic                          mem_we,
  input  logic [addr_w-1:0]             mem_adr,
  input  logic [mem_bus_pkg::ben_w-1:0] mem_ben,
  input  logic [mem_bus_pkg::xlen-1:0]  mem_wdt,
  output logic [mem_bus_pkg::xlen-1:0]  mem_rdt
);

  // number of words
  localparam int unsigned depth = 2 ** addr_w;

  logic [mem_bus_pkg::xlen-1:0] mem [depth];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  // only enabled lanes change
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      for (int i = 0; i < mem_bus_pkg::ben_w; i++) begin
        if (mem_ben[i]) begin
          mem[mem_adr][8*i +: 8] <= mem_wdt[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // read data valid the cycle after the request
  // a write keeps the previous read data
  always_ff @(posedge clk) begin
    if (mem_en && !mem_we) begin
      mem_rdt <= mem[mem_adr];
    end
  end

endmodule

`default_nettype wire

// ==== lsu_lane_map.sv ====
//////////////////////////////////////////////////
// lsu execute stage, word address and lane rotation
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_lane_map #(
  parameter int unsigned addr_w = 8
) (
  input  logic                          d_vld,
  input  logic                          d_we,
  input  logic [mem_bus_pkg::xlen-1:0]  d_adr,
  input  logic [mem_bus_pkg::xlen-1:0]  d_wdt,
  input  mem_bus_pkg::siz_t             d_siz,
  input  mem_bus_pkg::sts_t             d_sts,
  output logic                          mem_en,
  output logic                          mem_we,
  output logic [addr_w-1:0]             mem_adr,
  output logic [mem_bus_pkg::ben_w-1:0] mem_ben,
  output logic [mem_bus_pkg::xlen-1:0]  mem_wdt,
  output logic [1:0]                    x_ofs
);

  // enables before rotation, aligned to lane 0
  logic [mem_bus_pkg::ben_w-1:0]       ben_raw;
  // data bus split into byte lanes
  logic [mem_bus_pkg::ben_w-1:0][7:0]  wdt_lane;
  logic [mem_bus_pkg::ben_w-1:0][7:0]  rot_lane;

  //////////////////////////////////////////////////
  // request control
  //////////////////////////////////////////////////

  // only clean loads/stores reach the sram
  assign mem_en = d_vld && (d_sts == mem_bus_pkg::sts_ok);
  assign mem_we = mem_en && d_we;

  // drop the byte offset, wraps at the sram size
  assign mem_adr = d_adr[addr_w+1:2];
  assign x_ofs   = d_adr[1:0];

  //////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////

  always_comb begin
    case (d_siz)
      mem_bus_pkg::siz_b: ben_raw = {{(mem_bus_pkg::ben_w-1){1'b0}}, 1'b1};
      mem_bus_pkg::siz_h: ben_raw = {{(mem_bus_pkg::ben_w-2){1'b0}}, 2'b11};
      default:            ben_raw = '1;
    endcase
  end

  //////////////////////////////////////////////////
  // lane rotation, little endian
  //////////////////////////////////////////////////

  assign wdt_lane = d_wdt;

  // lane i takes source byte (i - offset) mod lanes
  for (genvar i = 0; i < mem_bus_pkg::ben_w; i++) begin : g_lane
    logic [1:0] sel;
    assign sel         = 2'(i) - x_ofs;
    assign mem_ben[i]  = ben_raw[sel];
    assign rot_lane[i] = wdt_lane[sel];
  end

  assign mem_wdt = rot_lane;

endmodule

`default_nettype wire

// ==== lsu_decode.sv ====
//////////////////////////////////////////////////
// lsu decode stage, address add, alignment check
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module lsu_decode (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_vld,
  input  rv_isa_pkg::insn_u            in_insn,
  input  logic [mem_bus_pkg::xlen-1:0] in_base,
  input  logic [mem_bus_pkg::xlen-1:0] in_wdt,
  output logic                         d_vld,
  output logic                         d_we,
  output logic                         d_sign,
  output logic [mem_bus_pkg::xlen-1:0] d_adr,
  output logic [mem_bus_pkg::xlen-1:0] d_wdt,
  output mem_bus_pkg::siz_t            d_siz,
  output logic [4:0]                   d_rd,
  output mem_bus_pkg::sts_t            d_sts
);

  logic                         is_ld;
  logic                         is_st;
  logic [2:0]                   f3;
  logic [mem_bus_pkg::xlen-1:0] imm;
  logic [mem_bus_pkg::xlen-1:0] adr;
  mem_bus_pkg::siz_t            siz;
  logic                         sign;
  logic                         f3_ok;
  logic                         mal;
  mem_bus_pkg::sts_t            sts;

  //////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////

  // opcode sits in the same bits in both views
  assign is_ld = (in_insn.ld.opcode == rv_isa_pkg::opc_load);
  assign is_st = (in_insn.st.opcode == rv_isa_pkg::opc_store);
  assign f3    = in_insn.ld.funct3;

  // sign extended immediate, s-type is split in two
  always_comb begin
    if (is_st) begin
      imm = {{(mem_bus_pkg::xlen-12){in_insn.st.imm_hi[6]}},
             in_insn.st.imm_hi, in_insn.st.imm_lo};
    end else begin
      imm = {{(mem_bus_pkg::xlen-12){in_insn.ld.imm[11]}}, in_insn.ld.imm};
    end
  end

  // effective byte address
  assign adr = in_base + imm;

  // size and sign from funct3
  always_comb begin
    siz   = mem_bus_pkg::siz_w;
    sign  = 1'b0;
    f3_ok = 1'b1;
    if (is_ld) begin
      case (f3)
        rv_isa_pkg::f3_lb: begin
          siz  = mem_bus_pkg::siz_b;
          sign = 1'b1;
        end
        rv_isa_pkg::f3_lh: begin
          siz  = mem_bus_pkg::siz_h;
          sign = 1'b1;
        end
        rv_isa_pkg::f3_lw:  siz = mem_bus_pkg::siz_w;
        rv_isa_pkg::f3_lbu: siz = mem_bus_pkg::siz_b;
        rv_isa_pkg::f3_lhu: siz = mem_bus_pkg::siz_h;
        default:            f3_ok = 1'b0;
      endcase
    end else begin
      case (f3)
        rv_isa_pkg::f3_sb: siz = mem_bus_pkg::siz_b;
        rv_isa_pkg::f3_sh: siz = mem_bus_pkg::siz_h;
        rv_isa_pkg::f3_sw: siz = mem_bus_pkg::siz_w;
        default:           f3_ok = 1'b0;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // alignment and status
  //////////////////////////////////////////////////

  // low address bits must be zero for the size
  always_comb begin
    case (siz)
      mem_bus_pkg::siz_b: mal = 1'b0;
      mem_bus_pkg::siz_h: mal = adr[0];
      mem_bus_pkg::siz_w: mal = |adr[1:0];
      default:            mal = 1'b1;
    endcase
  end

  // illegal has priority over misaligned
  always_comb begin
    if (!(is_ld || is_st) || !f3_ok) begin
      sts = mem_bus_pkg::sts_ill;
    end else if (mal) begin
      sts = mem_bus_pkg::sts_mal;
    end else begin
      sts = mem_bus_pkg::sts_ok;
    end
  end

  //////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      d_vld <= 1'b0;
    end else begin
      d_vld <= in_vld;
    end
  end

  // payload, loaded only on a strobe
  always_ff @(posedge clk) begin
    if (in_vld) begin
      d_we   <= is_st;
      d_sign <= sign;
      d_adr  <= adr;
      d_wdt  <= in_wdt;
      d_siz  <= siz;
      // raw bits 11:7, only meaningful for loads
      d_rd   <= in_insn.ld.rd;
      d_sts  <= sts;
    end
  end

endmodule

`default_nettype wire

// ==== mem_bus_pkg.sv ====
//////////////////////////////////////////////////
// memory bus widths, access size and status codes
//////////////////////////////////////////////////
`default_nettype none

package mem_bus_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // data width
  localparam int unsigned xlen  = 32;
  // byte lanes on the data bus
  localparam int unsigned ben_w = xlen / 8;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // log2 of access bytes
  typedef enum logic [1:0] {
    siz_b = 2'd0,
    siz_h = 2'd1,
    siz_w = 2'd2
  } siz_t;

  // per instruction status
  typedef enum logic [1:0] {
    sts_ok  = 2'd0,
    // address not aligned to access size
    sts_mal = 2'd1,
    // not a load/store, or reserved funct3
    sts_ill = 2'd2
  } sts_t;

endpackage

`default_nettype wire

// ==== rv_isa_pkg.sv ====
//////////////////////////////////////////////////
// rv32 load/store opcodes, funct3 codes and the
// instruction word union (i-type and s-type views)
//////////////////////////////////////////////////
`default_nettype none

package rv_isa_pkg;

  //////////////////////////////////////////////////
  // major opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;

  //////////////////////////////////////////////////
  // funct3 codes
  //////////////////////////////////////////////////

  // loads, bit 2 selects zero extension
  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;
  // stores
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sh  = 3'b001;
  localparam logic [2:0] f3_sw  = 3'b010;

  //////////////////////////////////////////////////
  // instruction formats
  //////////////////////////////////////////////////

  // i-type, used by loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_ld_t;

  // s-type, immediate split around rs2/rs1/funct3
  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } insn_st_t;

  // same 32 bits, two decodings
  typedef union packed {
    insn_ld_t ld;
    insn_st_t st;
  } insn_u;

endpackage

`default_nettype wire
